// ==== Bender.yml ====
package:
  name: neopixel

sources:
  - neoPixelPkg.sv
  - neoPixelRam.sv
  - neoPixelRegisters.sv
  - neoPixelStreamer.sv
  - neoPixelInitTimer.sv
  - neoPixelTop.sv
  - target: test
    files:
      - tbNeoPixel.sv

// ==== neoPixelInitTimer.sv ====
module neoPixelInitTimer import neoPixelPkg::*; (
  input  logic busClk,
  input  logic rst,
  input  logic initSlow,
  output logic initDone
);

  logic [initBits-1:0] initCnt;
  logic                fired;

  always_ff @(posedge busClk) begin
    if (rst) begin
      initCnt  <= '0;
      fired    <= 1'b0;
      initDone <= 1'b0;
    end else begin
      initDone <= 1'b0;
      if (!initSlow) begin
        // ready for the next init request
        initCnt <= '0;
        fired   <= 1'b0;
      end else if (!fired) begin
        if (initCnt == initBits'(initCycles - 1)) begin
          initDone <= 1'b1;
          fired    <= 1'b1;
        end else begin
          initCnt <= initCnt + 1'b1;
        end
      end
    end
  end

endmodule

// ==== neoPixelPkg.sv ====
package neoPixelPkg;

  // frame buffer geometry, one byte per pixel colour
  localparam int bufferEnd  = 255;
  localparam int bufferBits = 8;

  // busAddr bit that switches from the buffer to the register file
  localparam int regSelBit = 13;

  // register offsets taken from busAddr[2:0]
  localparam logic [2:0] regMaxLo  = 3'd0;
  localparam logic [2:0] regMaxHi  = 3'd1;
  localparam logic [2:0] regCtrl   = 3'd2;
  localparam logic [2:0] regStatus = 3'd3;

  // bit timing in busClk cycles, kept short so a frame simulates quickly
  localparam int bitCycles   = 20;
  localparam int t0High      = 6;
  localparam int t1High      = 13;
  localparam int latchCycles = 100;
  localparam int initCycles  = 400;

  // the streamer counter has to cover both the bit period and the latch gap
  localparam int cycBits  = $clog2((latchCycles > bitCycles) ? latchCycles : bitCycles);
  localparam int initBits = $clog2(initCycles);

  // last byte index used when limit is set
  typedef logic [12:0] regMax_t;

  // read-back layout is {mode32, loop, run, limit, init} with init in bit 0
  typedef struct packed {
    logic mode32;
    logic loop;
    logic run;
    logic limit;
    logic init;
  } neoCtrl_t;

endpackage

// ==== neoPixelRam.sv ====
module neoPixelRam import neoPixelPkg::*; (
  input  logic                  busClk,
  input  logic                  wr,
  input  logic [bufferBits-1:0] wAddr,
  input  logic [7:0]            dIn,
  input  logic [bufferBits-1:0] rAddr,
  output logic [7:0]            dOut
);

  logic [7:0]            mem [bufferEnd+1];
  logic [bufferBits-1:0] rAddrQ;

  always_ff @(posedge busClk) begin
    if (wr) begin
      mem[wAddr] <= dIn;
    end
  end

  // two stage read, the address is registered and so is the data
  always_ff @(posedge busClk) begin
    rAddrQ <= rAddr;
    dOut   <= mem[rAddrQ];
  end

endmodule

// ==== neoPixelRegisters.sv ====
module neoPixelRegisters import neoPixelPkg::*; (
  input  logic                  busClk,
  input  logic                  rst,
  input  logic [regSelBit:0]    busAddr,
  input  logic [7:0]            busDataIn,
  input  logic                  busWrite,
  input  logic                  busRead,
  output logic [7:0]            busDataOut,
  input  logic [bufferBits-1:0] pixelIx,
  output logic [7:0]            pixelByte,
  input  logic                  syncIn,
  input  logic                  frameDone,
  input  logic                  busy,
  input  logic                  initDone,
  output neoCtrl_t              ctrl,
  output regMax_t               regMax,
  output logic                  initSlow
);

  logic                  ramWr;
  logic [bufferBits-1:0] ramWAddr;
  logic [7:0]            ramWData;
  logic                  selReg;
  logic [2:0]            regOffset;

  assign selReg    = busAddr[regSelBit];
  assign regOffset = busAddr[2:0];

  // buffer writes go through one register stage before reaching the RAM
  always_ff @(posedge busClk) begin
    if (rst) begin
      ramWr <= 1'b0;
    end else begin
      ramWr <= busWrite && !selReg;
    end
  end

  // address and data are captured with the strobe so the bus may move on
  always_ff @(posedge busClk) begin
    if (busWrite && !selReg) begin
      ramWAddr <= busAddr[bufferBits-1:0];
      ramWData <= busDataIn;
    end
  end

  neoPixelRam iRam (
    .busClk (busClk),
    .wr     (ramWr),
    .wAddr  (ramWAddr),
    .dIn    (ramWData),
    .rAddr  (pixelIx),
    .dOut   (pixelByte)
  );

  // later statements win, which gives the priority order of the control bits
  always_ff @(posedge busClk) begin
    if (rst) begin
      ctrl     <= '0;
      regMax   <= '0;
      initSlow <= 1'b0;
    end else begin
      if (frameDone) begin
        ctrl.run <= ctrl.loop;
      end

      if (syncIn) begin
        ctrl.run <= 1'b1;
      end

      if (initDone) begin
        ctrl.init <= 1'b0;
        initSlow  <= 1'b0;
      end

      // initSlow is only raised on entry so that initDone can drop it again
      if (ctrl.init) begin
        ctrl.limit  <= 1'b0;
        ctrl.run    <= 1'b0;
        ctrl.loop   <= 1'b0;
        ctrl.mode32 <= 1'b0;
        if (!initSlow) begin
          initSlow <= 1'b1;
        end
      end

      if (busWrite && selReg) begin
        case (regOffset)
          regMaxLo: regMax[7:0]  <= busDataIn;
          regMaxHi: regMax[12:8] <= busDataIn[4:0];
          regCtrl:  ctrl         <= neoCtrl_t'(busDataIn[4:0]);
          default:  ;
        endcase
      end
    end
  end

  // read data is registered and holds until the next read strobe
  always_ff @(posedge busClk) begin
    if (rst) begin
      busDataOut <= '0;
    end else if (busRead) begin
      if (!selReg) begin
        // the frame buffer has no bus read port
        busDataOut <= 8'hFF;
      end else begin
        case (regOffset)
          regMaxLo:  busDataOut <= regMax[7:0];
          regMaxHi:  busDataOut <= {3'b000, regMax[12:8]};
          regCtrl:   busDataOut <= {3'b000, ctrl};
          regStatus: busDataOut <= {7'b0000000, busy};
          default:   busDataOut <= '0;
        endcase
      end
    end
  end

endmodule

// ==== neoPixelStreamer.sv ====
module neoPixelStreamer import neoPixelPkg::*; (
  input  logic                  busClk,
  input  logic                  rst,
  input  neoCtrl_t              ctrl,
  input  regMax_t               regMax,
  input  logic                  initSlow,
  output logic [bufferBits-1:0] pixelIx,
  input  logic [7:0]            pixelByte,
  output logic                  pixelOut,
  output logic                  busy,
  output logic                  frameDone
);

  typedef enum logic [1:0] {
    stIdle,
    stPrefetch,
    stShift,
    stLatch
  } state_t;

  state_t       state;
  logic [cycBits-1:0] cycCnt;
  logic [2:0]   bitCnt;
  logic [7:0]   shiftReg;
  logic         lastByte;
  regMax_t      fetchIx;
  regMax_t      nextIx;
  regMax_t      lastIx;
  logic         nextIsLast;
  logic [cycBits-1:0] highLen;

  assign pixelIx = fetchIx[bufferBits-1:0];

  // in 32-bit mode every index ending in binary 11 is padding and is skipped
  assign nextIx = fetchIx + ((ctrl.mode32 && fetchIx[1:0] == 2'd2) ? 13'd2 : 13'd1);
  assign lastIx = ctrl.limit ? regMax : regMax_t'(bufferEnd);

  // the byte being loaded is the last one when its successor is out of range
  assign nextIsLast = (nextIx > lastIx) || (nextIx > regMax_t'(bufferEnd));

  assign highLen = shiftReg[7] ? cycBits'(t1High) : cycBits'(t0High);

  always_ff @(posedge busClk) begin
    if (rst) begin
      state     <= stIdle;
      cycCnt    <= '0;
      bitCnt    <= '0;
      fetchIx   <= '0;
      busy      <= 1'b0;
      frameDone <= 1'b0;
    end else begin
      frameDone <= 1'b0;
      if (initSlow) begin
        // a slow init aborts whatever was streaming
        state   <= stIdle;
        cycCnt  <= '0;
        bitCnt  <= '0;
        fetchIx <= '0;
        busy    <= 1'b0;
      end else begin
        case (state)
          stIdle: begin
            // frameDone still pending means run has not been updated yet
            if (ctrl.run && !busy && !frameDone) begin
              state  <= stPrefetch;
              cycCnt <= '0;
              busy   <= 1'b1;
            end
          end

          stPrefetch: begin
            // two cycles cover the RAM address register and output register
            if (cycCnt == cycBits'(1)) begin
              state   <= stShift;
              cycCnt  <= '0;
              bitCnt  <= '0;
              fetchIx <= nextIx;
            end else begin
              cycCnt <= cycCnt + 1'b1;
            end
          end

          stShift: begin
            if (cycCnt == cycBits'(bitCycles - 1)) begin
              cycCnt <= '0;
              if (bitCnt == 3'd7) begin
                bitCnt <= '0;
                if (lastByte) begin
                  state <= stLatch;
                end else begin
                  fetchIx <= nextIx;
                end
              end else begin
                bitCnt <= bitCnt + 1'b1;
              end
            end else begin
              cycCnt <= cycCnt + 1'b1;
            end
          end

          stLatch: begin
            if (cycCnt == cycBits'(latchCycles - 1)) begin
              state     <= stIdle;
              cycCnt    <= '0;
              fetchIx   <= '0;
              busy      <= 1'b0;
              frameDone <= 1'b1;
            end else begin
              cycCnt <= cycCnt + 1'b1;
            end
          end

          default: state <= stIdle;
        endcase
      end
    end
  end

  // shift register and last-byte flag are loaded whenever a new byte starts
  always_ff @(posedge busClk) begin
    if ((state == stPrefetch && cycCnt == cycBits'(1)) ||
        (state == stShift && cycCnt == cycBits'(bitCycles - 1) && bitCnt == 3'd7)) begin
      shiftReg <= pixelByte;
      lastByte <= nextIsLast;
    end else if (state == stShift && cycCnt == cycBits'(bitCycles - 1)) begin
      shiftReg <= {shiftReg[6:0], 1'b0};
    end
  end

  // the line is registered, one cycle behind the counters for every bit alike
  always_ff @(posedge busClk) begin
    if (rst) begin
      pixelOut <= 1'b0;
    end else begin
      pixelOut <= !initSlow && state == stShift && cycCnt < highLen;
    end
  end

endmodule

// ==== neoPixelTop.sv ====
module neoPixelTop import neoPixelPkg::*; (
  input  logic               busClk,
  input  logic               rst,
  input  logic [regSelBit:0] busAddr,
  input  logic [7:0]         busDataIn,
  input  logic               busWrite,
  input  logic               busRead,
  output logic [7:0]         busDataOut,
  input  logic               syncIn,
  output logic               pixelOut
);

  neoCtrl_t              ctrl;
  regMax_t               regMax;
  logic                  initSlow;
  logic                  initDone;
  logic [bufferBits-1:0] pixelIx;
  logic [7:0]            pixelByte;
  logic                  busy;
  logic                  frameDone;

  neoPixelRegisters iRegisters (
    .busClk     (busClk),
    .rst        (rst),
    .busAddr    (busAddr),
    .busDataIn  (busDataIn),
    .busWrite   (busWrite),
    .busRead    (busRead),
    .busDataOut (busDataOut),
    .pixelIx    (pixelIx),
    .pixelByte  (pixelByte),
    .syncIn     (syncIn),
    .frameDone  (frameDone),
    .busy       (busy),
    .initDone   (initDone),
    .ctrl       (ctrl),
    .regMax     (regMax),
    .initSlow   (initSlow)
  );

  neoPixelStreamer iStreamer (
    .busClk    (busClk),
    .rst       (rst),
    .ctrl      (ctrl),
    .regMax    (regMax),
    .initSlow  (initSlow),
    .pixelIx   (pixelIx),
    .pixelByte (pixelByte),
    .pixelOut  (pixelOut),
    .busy      (busy),
    .frameDone (frameDone)
  );

  neoPixelInitTimer iInitTimer (
    .busClk   (busClk),
    .rst      (rst),
    .initSlow (initSlow),
    .initDone (initDone)
  );

endmodule

// ==== tb.f ====
neoPixelPkg.sv
neoPixelRam.sv
neoPixelRegisters.sv
neoPixelStreamer.sv
neoPixelInitTimer.sv
neoPixelTop.sv
tbNeoPixel.sv

// ==== tbNeoPixel.sv ====
module tbNeoPixel import neoPixelPkg::*; ();

  // one full frame of the buffer including prefetch and latch gap
  localparam int frameCycles   = (bufferEnd + 1) * 8 * bitCycles + latchCycles + 2;
  localparam int timeoutCycles = 3 * frameCycles + initCycles + 2000;

  logic               busClk;
  logic               rst;
  logic [regSelBit:0] busAddr;
  logic [7:0]         busDataIn;
  logic               busWrite;
  logic               busRead;
  logic [7:0]         busDataOut;
  logic               syncIn;
  logic               pixelOut;

  int          valueErrors;
  int          otherErrors;
  int          cycleCount;
  logic [23:0] lfsr;
  logic [7:0]  bufModel [bufferEnd+1];
  logic [7:0]  expBytes[$];
  logic [7:0]  checkFrame[$];

  // decoder state
  logic [7:0] frameBytes[$];
  logic [7:0] lastFrame[$];
  logic [7:0] prevFrame[$];
  logic [7:0] curByte;
  int         bitIx;
  int         highCnt;
  int         lowCnt;
  int         riseGap;
  int         pulseCount;
  int         frameCount;
  logic       inFrame;
  logic       abortOk;
  logic       lowWindow;

  neoPixelTop i_neoPixelTop (
    .busClk     (busClk),
    .rst        (rst),
    .busAddr    (busAddr),
    .busDataIn  (busDataIn),
    .busWrite   (busWrite),
    .busRead    (busRead),
    .busDataOut (busDataOut),
    .syncIn     (syncIn),
    .pixelOut   (pixelOut)
  );

  initial begin
    busClk = 1'b0;
    forever #5 busClk = !busClk;
  end

  // the line must stay low while the slow init runs
  assert property (@(posedge busClk) disable iff (rst) lowWindow |-> !pixelOut)
    else begin
      $display("** Error @ %0t: pixelOut = 1, expected 0", $time);
      valueErrors++;
    end

  function automatic logic [23:0] lfsrNext(input logic [23:0] s);
    return {s[22:0], s[23] ^ s[22] ^ s[21] ^ s[16]};
  endfunction

  function automatic logic [regSelBit:0] regAddr(input logic [2:0] offset);
    return {1'b1, 10'd0, offset};
  endfunction

  task automatic checkValue(input string name, input int got, input int exp);
    assert (got == exp)
      else begin
        $display("** Error @ %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        valueErrors++;
      end
  endtask

  task automatic writeByte(input logic [regSelBit:0] addr, input logic [7:0] data);
    @(negedge busClk);
    busAddr   = addr;
    busDataIn = data;
    busWrite  = 1'b1;
    @(negedge busClk);
    busWrite = 1'b0;
  endtask

  task automatic readByte(input logic [regSelBit:0] addr, output logic [7:0] data);
    @(negedge busClk);
    busAddr = addr;
    busRead = 1'b1;
    @(negedge busClk);
    busRead = 1'b0;
    data    = busDataOut;
  endtask

  task automatic checkRead(input logic [regSelBit:0] addr, input logic [7:0] exp,
                           input string name);
    logic [7:0] rd;
    readByte(addr, rd);
    checkValue(name, rd, exp);
  endtask

  task automatic waitIdle();
    logic [7:0] st;
    st = 8'h01;
    while (st[0]) begin
      readByte(regAddr(regStatus), st);
    end
  endtask

  task automatic pulseSync();
    @(negedge busClk);
    syncIn = 1'b1;
    @(negedge busClk);
    syncIn = 1'b0;
  endtask

  // each byte takes eight LFSR steps with one bit per step
  task automatic fillBuffer(input int count);
    logic [7:0] b;
    for (int i = 0; i < count; i++) begin
      b = '0;
      for (int k = 0; k < 8; k++) begin
        lfsr = lfsrNext(lfsr);
        b    = {b[6:0], lfsr[0]};
      end
      bufModel[i] = b;
      writeByte({1'b0, 5'd0, i[7:0]}, b);
    end
  endtask

  // padding bytes sit at indices ending in binary 11 and drop out of the expected order
  task automatic buildExpected(input int lastIx, input logic skipPad);
    expBytes.delete();
    for (int i = 0; i <= lastIx; i++) begin
      if (!(skipPad && (i % 4) == 3)) begin
        expBytes.push_back(bufModel[i]);
      end
    end
  endtask

  task automatic compareFrame(input string what);
    checkValue({what, " byte count"}, checkFrame.size(), expBytes.size());
    for (int i = 0; i < expBytes.size() && i < checkFrame.size(); i++) begin
      checkValue($sformatf("%s byte %0d", what, i), checkFrame[i], expBytes[i]);
    end
  endtask

  // the pulse decoder samples on the falling edge where pixelOut is stable
  always @(negedge busClk) begin
    if (rst) begin
      highCnt = 0;
      lowCnt  = 0;
      riseGap = 0;
      bitIx   = 0;
      inFrame = 1'b0;
    end else if (pixelOut) begin
      if (highCnt == 0) begin
        pulseCount++;
        if (inFrame && !abortOk) begin
          checkValue("bit period", riseGap, bitCycles);
        end
        inFrame = 1'b1;
        riseGap = 0;
      end
      highCnt++;
      lowCnt = 0;
      riseGap++;
    end else begin
      if (highCnt != 0) begin
        if (!abortOk && highCnt != t0High && highCnt != t1High) begin
          $display("Pulse of %0d cycles at %0t matches neither bit width", highCnt, $time);
          otherErrors++;
        end
        curByte = {curByte[6:0], (2 * highCnt) > (t0High + t1High)};
        bitIx++;
        if (bitIx == 8) begin
          frameBytes.push_back(curByte);
          bitIx = 0;
        end
        highCnt = 0;
      end
      lowCnt++;
      riseGap++;
      // a low stretch longer than a bit period closes the frame
      if (inFrame && lowCnt > bitCycles) begin
        prevFrame = lastFrame;
        lastFrame = frameBytes;
        frameBytes.delete();
        bitIx   = 0;
        inFrame = 1'b0;
        frameCount++;
      end
    end
  end

  always @(posedge busClk) begin
    cycleCount++;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
      $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    int f0;
    int p0;
    rst         = 1'b1;
    busAddr     = '0;
    busDataIn   = '0;
    busWrite    = 1'b0;
    busRead     = 1'b0;
    syncIn      = 1'b0;
    valueErrors = 0;
    otherErrors = 0;
    cycleCount  = 0;
    pulseCount  = 0;
    frameCount  = 0;
    curByte     = '0;
    abortOk     = 1'b0;
    lowWindow   = 1'b0;
    lfsr        = 24'd92380;
    repeat (10) @(negedge busClk);
    rst = 1'b0;

    fillBuffer(32);

    // register read-back with run clear
    writeByte(regAddr(regMaxLo), 8'hAB);
    writeByte(regAddr(regMaxHi), 8'hFF);
    writeByte(regAddr(regCtrl), 8'hFA);
    checkRead(regAddr(regMaxLo), 8'hAB, "regMaxLo");
    checkRead(regAddr(regMaxHi), 8'h1F, "regMaxHi");
    checkRead(regAddr(regCtrl), 8'h1A, "regCtrl");
    checkRead({1'b0, 13'h0005}, 8'hFF, "buffer read");
    checkRead(regAddr(regStatus), 8'h00, "status");

    // single frame limited to bytes 0 to 11
    writeByte(regAddr(regCtrl), 8'h00);
    writeByte(regAddr(regMaxHi), 8'h00);
    writeByte(regAddr(regMaxLo), 8'd11);
    f0 = frameCount;
    writeByte(regAddr(regCtrl), 8'h06);
    wait (frameCount == f0 + 1);
    waitIdle();
    buildExpected(11, 1'b0);
    checkFrame = lastFrame;
    compareFrame("limited frame");
    checkRead(regAddr(regStatus), 8'h00, "status");
    checkRead(regAddr(regCtrl), 8'h02, "regCtrl");

    // 32-bit mode drops every fourth byte
    writeByte(regAddr(regMaxLo), 8'd15);
    f0 = frameCount;
    writeByte(regAddr(regCtrl), 8'h16);
    wait (frameCount == f0 + 1);
    waitIdle();
    buildExpected(15, 1'b1);
    checkFrame = lastFrame;
    compareFrame("mode32 frame");

    // looping frames, then loop cleared during the latch gap
    writeByte(regAddr(regMaxLo), 8'd11);
    buildExpected(11, 1'b0);
    f0 = frameCount;
    writeByte(regAddr(regCtrl), 8'h0E);
    wait (frameCount == f0 + 2);
    checkFrame = prevFrame;
    compareFrame("first loop frame");
    checkFrame = lastFrame;
    compareFrame("second loop frame");
    checkRead(regAddr(regCtrl), 8'h0E, "regCtrl");
    writeByte(regAddr(regCtrl), 8'h06);
    waitIdle();
    checkRead(regAddr(regCtrl), 8'h02, "regCtrl");
    f0 = frameCount;
    p0 = pulseCount;
    repeat (300) @(negedge busClk);
    checkValue("pulse count", pulseCount, p0);

    // sync strobe starts exactly one frame
    pulseSync();
    wait (frameCount == f0 + 1);
    waitIdle();
    checkFrame = lastFrame;
    compareFrame("sync frame");
    p0 = pulseCount;
    repeat (300) @(negedge busClk);
    checkValue("pulse count", pulseCount, p0);
    checkRead(regAddr(regCtrl), 8'h02, "regCtrl");

    // slow init written in the middle of a looping frame
    p0 = pulseCount;
    writeByte(regAddr(regCtrl), 8'h0E);
    wait (pulseCount >= p0 + 20);
    abortOk = 1'b1;
    writeByte(regAddr(regCtrl), 8'h0F);
    checkRead(regAddr(regCtrl), 8'h01, "regCtrl");
    lowWindow = 1'b1;
    p0 = pulseCount;
    begin
      logic [7:0] rd;
      rd = 8'h01;
      while (rd != 8'h00) begin
        readByte(regAddr(regCtrl), rd);
      end
    end
    lowWindow = 1'b0;
    if (pulseCount != p0) begin
      $display("A pulse appeared on pixelOut during the slow init");
      otherErrors++;
    end
    if (lowCnt < initCycles) begin
      $display("pixelOut was low for only %0d cycles during the slow init", lowCnt);
      otherErrors++;
    end
    checkRead(regAddr(regStatus), 8'h00, "status");
    checkRead(regAddr(regCtrl), 8'h00, "regCtrl");
    abortOk = 1'b0;

    $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
